// File: logic/routerPkg.sv
`default_nettype none

package routerPkg;

  parameter int NumPorts = 5;

  // Port order doubles as the bit order of every per-port bus
  typedef enum logic [2:0] {
    localPort = 3'd0,
    northPort = 3'd1,
    eastPort  = 3'd2,
    westPort  = 3'd3,
    southPort = 3'd4
  } portIndex;

  typedef enum logic [2:0] {
    idleFlit = 3'd0,
    headFlit = 3'd1,
    bodyFlit = 3'd2,
    tailFlit = 3'd3
  } flitKind;

  typedef enum logic [5:0] {
    idleState  = 6'b000001,
    localGrant = 6'b000010,
    northGrant = 6'b000100,
    eastGrant  = 6'b001000,
    westGrant  = 6'b010000,
    southGrant = 6'b100000
  } arbState;

  typedef enum logic {
    enableReg = 1'b0,
    limitReg  = 1'b1
  } cfgAddress;

endpackage

`default_nettype wire

// File: logic/holdTimer.sv
`timescale 1ns/1ns
`default_nettype none

module holdTimer
  import routerPkg::*;
#(
  parameter int LengthWidth = 12
) (
  input  logic                   clk,
  input  logic                   rst,
  input  flitKind                flitId,
  input  logic [LengthWidth-1:0] pktLength,
  input  logic [LengthWidth-1:0] holdLimit,
  input  logic                   run,
  output logic                   timesUp
);

  logic [LengthWidth-1:0] budget;
  logic [LengthWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budget <= '0;
      count  <= '0;
    end
    else
    begin
      if (flitId == headFlit)
        budget <= (pktLength < holdLimit) ? pktLength : holdLimit; // Limit caps the header length
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign timesUp = (count == budget);

endmodule

`default_nettype wire

// File: logic/arbiterConfig.sv
`timescale 1ns/1ns
`default_nettype none

module arbiterConfig
  import routerPkg::*;
#(
  parameter int LengthWidth = 12
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   cfgWrite,
  input  cfgAddress              cfgAddr,
  input  logic [LengthWidth-1:0] cfgData,
  output logic [NumPorts-1:0]    portEnable,
  output logic [LengthWidth-1:0] holdLimit
);

  // Everything enabled and no extra cap until software says otherwise
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      portEnable <= '1;
      holdLimit  <= '1;
    end
    else if (cfgWrite)
    begin
      case (cfgAddr)
        enableReg:
        begin
          portEnable <= cfgData[NumPorts-1:0];
        end
        limitReg:
        begin
          holdLimit <= cfgData;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/outputArbiter.sv
`timescale 1ns/1ns
`default_nettype none

module outputArbiter
  import routerPkg::*;
#(
  parameter int LengthWidth = 12
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [NumPorts-1:0]    req,
  input  logic [NumPorts-1:0]    portEnable,
  input  flitKind                flitId [NumPorts],
  input  logic [LengthWidth-1:0] pktLength [NumPorts],
  input  logic [LengthWidth-1:0] holdLimit,
  output arbState                grant
);

  logic [NumPorts-1:0] maskedReq;
  logic [NumPorts-1:0] run;
  logic [NumPorts-1:0] timesUp;
  arbState             nextGrant;
  portIndex            holder;
  logic                holderValid;

  // One-hot grant code for a port, bit 0 being idle
  function automatic arbState stateOf(input int idx);
    logic [NumPorts:0] oneHot;
    oneHot          = '0;
    oneHot[idx + 1] = 1'b1;
    return arbState'(oneHot);
  endfunction

  assign maskedReq = req & portEnable;

  for (genvar p = 0; p < NumPorts; p++)
  begin : gTimer
    holdTimer #(
      .LengthWidth(LengthWidth)
    ) timer (
      .clk      (clk),
      .rst      (rst),
      .flitId   (flitId[p]),
      .pktLength(pktLength[p]),
      .holdLimit(holdLimit),
      .run      (run[p]),
      .timesUp  (timesUp[p])
    );
  end

  // Which port the current state belongs to, if any
  always_comb
  begin
    holder      = localPort;
    holderValid = 1'b0;
    for (int p = 0; p < NumPorts; p++)
    begin
      if (grant == stateOf(p))
      begin
        holder      = portIndex'(p);
        holderValid = 1'b1;
      end
    end
  end

  always_comb
  begin
    nextGrant = idleState;
    run       = '0;
    if (grant == idleState)
    begin
      // Scanning downwards leaves the lowest requester, so Local wins ties
      for (int k = NumPorts - 1; k >= 0; k--)
      begin
        if (maskedReq[k])
          nextGrant = stateOf(k);
      end
    end
    else if (holderValid)
    begin
      if (maskedReq[holder] && !timesUp[holder])
      begin
        run[holder] = 1'b1;
        nextGrant   = grant;
      end
      else
      begin
        // Rotate from the port after the holder; the holder itself is skipped
        for (int k = NumPorts - 1; k >= 1; k--)
        begin
          if (maskedReq[(int'(holder) + k) % NumPorts])
            nextGrant = stateOf((int'(holder) + k) % NumPorts);
        end
      end
    end
    // A corrupted state code falls back to idle
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= idleState;
    else
      grant <= nextGrant;
  end

endmodule

`default_nettype wire

// File: logic/outputMux.sv
`timescale 1ns/1ns
`default_nettype none

module outputMux
  import routerPkg::*;
#(
  parameter int FlitWidth = 16
) (
  input  logic                 clk,
  input  logic                 rst,
  input  arbState              grant,
  input  logic [NumPorts-1:0]  req,
  input  logic [FlitWidth-1:0] flitData [NumPorts],
  output logic [FlitWidth-1:0] outFlit,
  output logic                 outValid,
  output portIndex             outPort
);

  portIndex sel;
  logic     isPort;

  always_comb
  begin
    sel    = localPort;
    isPort = 1'b0;
    for (int p = 0; p < NumPorts; p++)
    begin
      if (grant[p + 1])
      begin
        sel    = portIndex'(p);
        isPort = 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outFlit  <= '0;
      outValid <= 1'b0;
      outPort  <= localPort;
    end
    else
    begin
      outFlit  <= flitData[sel];
      outPort  <= sel;
      outValid <= isPort && req[sel]; // Granted port must still be asking
    end
  end

endmodule

`default_nettype wire

// File: logic/outputPort.sv
`timescale 1ns/1ns
`default_nettype none

module outputPort
  import routerPkg::*;
#(
  parameter int FlitWidth   = 16,
  parameter int LengthWidth = 12
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [NumPorts-1:0]    req,
  input  flitKind                flitId [NumPorts],
  input  logic [LengthWidth-1:0] pktLength [NumPorts],
  input  logic [FlitWidth-1:0]   flitData [NumPorts],
  input  logic                   cfgWrite,
  input  cfgAddress              cfgAddr,
  input  logic [LengthWidth-1:0] cfgData,
  output arbState                grant,
  output logic [FlitWidth-1:0]   outFlit,
  output logic                   outValid,
  output portIndex               outPort
);

  logic [NumPorts-1:0]    portEnable;
  logic [LengthWidth-1:0] holdLimit;

  arbiterConfig #(
    .LengthWidth(LengthWidth)
  ) config0 (
    .clk       (clk),
    .rst       (rst),
    .cfgWrite  (cfgWrite),
    .cfgAddr   (cfgAddr),
    .cfgData   (cfgData),
    .portEnable(portEnable),
    .holdLimit (holdLimit)
  );

  outputArbiter #(
    .LengthWidth(LengthWidth)
  ) arbiter0 (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .portEnable(portEnable),
    .flitId    (flitId),
    .pktLength (pktLength),
    .holdLimit (holdLimit),
    .grant     (grant)
  );

  outputMux #(
    .FlitWidth(FlitWidth)
  ) mux0 (
    .clk     (clk),
    .rst     (rst),
    .grant   (grant),
    .req     (req),
    .flitData(flitData),
    .outFlit (outFlit),
    .outValid(outValid),
    .outPort (outPort)
  );

endmodule

`default_nettype wire

// File: tb/outputPortChecker.sv
`timescale 1ns/1ns
`default_nettype none

module outputPortChecker
  import routerPkg::*;
#(
  parameter int FlitWidth = 16
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [NumPorts-1:0]  req,
  input  arbState              grant,
  input  logic [FlitWidth-1:0] outFlit,
  input  logic                 outValid,
  input  portIndex             outPort,
  input  arbState              expGrant,
  input  logic                 rowActive,
  input  logic [11:0]          cycleCount,
  output int                   errorCount,
  output int                   checkCount
);

  int                  errors    = 0;
  int                  checks    = 0;
  logic                primed    = 1'b0;
  logic                inReset   = 1'b1;
  logic                expActive = 1'b0;
  logic [5:0]          expected;
  logic [5:0]          lastGrant;
  logic [NumPorts-1:0] lastReq;
  logic [11:0]         lastCount;

  assign errorCount = errors;
  assign checkCount = checks;

  // Port index of a one-hot grant code; idle and broken codes give -1
  function automatic int grantedPort(input logic [5:0] code);
    case (code)
      6'b000010: return 0;
      6'b000100: return 1;
      6'b001000: return 2;
      6'b010000: return 3;
      6'b100000: return 4;
      default:   return -1;
    endcase
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("CHECK FAILED %s got %0h expected %0h at %0t", name, got, want, $time);
    end
  endtask

  // Take the same view of the inputs that the DUT takes at this edge
  always @(posedge clk)
  begin
    primed    <= 1'b1;
    inReset   <= rst;
    expActive <= rowActive;
    expected  <= expGrant;
    lastGrant <= expActive ? expected : idleState; // Outside the rows nothing requests
    lastReq   <= req;
    lastCount <= cycleCount;
  end

  always @(negedge clk)
  begin
    int   port;
    logic expValid;
    port     = grantedPort(lastGrant);
    expValid = 1'b0;
    if (port >= 0)
      expValid = lastReq[port];
    if (primed && inReset)
    begin
      compare("grant", grant, idleState);
      compare("outValid", outValid, 1'b0);
    end
    else if (primed)
    begin
      if (expActive)
        compare("grant", grant, expected);
      compare("outValid", outValid, expValid);
      if (outValid)
      begin
        compare("outPort", outPort, port);
        compare("outFlit port nibble", outFlit[FlitWidth-1 -: 4], outPort);
        compare("outFlit count", outFlit[FlitWidth-5:0], lastCount); // Sent one cycle late
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/outputPortTb.sv
`timescale 1ns/1ns
`default_nettype none

module outputPortTb
  import routerPkg::*;
();

  localparam int FlitWidth   = 16;
  localparam int LengthWidth = 12;
  localparam int MaxCycles   = 200;
  localparam int ResetCycles = 8;

  logic                   clk;
  logic                   rst;
  logic [NumPorts-1:0]    req;
  flitKind                flitId [NumPorts];
  logic [LengthWidth-1:0] pktLength [NumPorts];
  logic [FlitWidth-1:0]   flitData [NumPorts] = '{default: '0};
  logic                   cfgWrite;
  cfgAddress              cfgAddr;
  logic [LengthWidth-1:0] cfgData;
  arbState                grant;
  logic [FlitWidth-1:0]   outFlit;
  logic                   outValid;
  portIndex               outPort;

  arbState                expGrant;
  logic                   rowActive;
  logic [11:0]            cycleCount = '0;
  int                     errorCount;
  int                     checkCount;

  outputPort #(
    .FlitWidth  (FlitWidth),
    .LengthWidth(LengthWidth)
  ) DUT (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .flitId   (flitId),
    .pktLength(pktLength),
    .flitData (flitData),
    .cfgWrite (cfgWrite),
    .cfgAddr  (cfgAddr),
    .cfgData  (cfgData),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outPort  (outPort)
  );

  outputPortChecker #(
    .FlitWidth(FlitWidth)
  ) monitor (
    .clk       (clk),
    .req       (req),
    .rst       (rst),
    .grant     (grant),
    .outFlit   (outFlit),
    .outValid  (outValid),
    .outPort   (outPort),
    .expGrant  (expGrant),
    .rowActive (rowActive),
    .cycleCount(cycleCount),
    .errorCount(errorCount),
    .checkCount(checkCount)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Every flit names its source port in the top nibble and the cycle below it
  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 12'd1;
    for (int p = 0; p < NumPorts; p++)
      flitData[p] <= {4'(p), cycleCount + 12'd1};
  end

  initial
  begin
    int    fd;
    int    fields;
    int    cycles;
    int    rq;
    int    kind [NumPorts];
    int    len [NumPorts];
    int    cw;
    int    ca;
    int    cd;
    int    eg;
    bit    atEnd;
    bit    runBroken;
    string line;

    rst       = 1'b1;
    req       = '0;
    cfgWrite  = 1'b0;
    cfgAddr   = enableReg;
    cfgData   = '0;
    expGrant  = idleState;
    rowActive = 1'b0;
    for (int p = 0; p < NumPorts; p++)
    begin
      flitId[p]    = idleFlit;
      pktLength[p] = '0;
    end
    atEnd     = 1'b0;
    runBroken = 1'b0;
    cycles    = 0;

    fd = $fopen("tb/outputPortInput.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the stimulus file tb/outputPortInput.txt");
      runBroken = 1'b1;
    end
    else
    begin
      repeat (ResetCycles) @(posedge clk);
      rst <= 1'b0;
      while (!atEnd && cycles < MaxCycles)
      begin
        if ($fgets(line, fd) == 0)
          atEnd = 1'b1;
        else
        begin
          fields = $sscanf(line, "%h %d %d %d %d %d %h %h %h %h %h %d %d %h %h", rq,
                           kind[0], kind[1], kind[2], kind[3], kind[4],
                           len[0], len[1], len[2], len[3], len[4], cw, ca, cd, eg);
          if (fields == 15) // Comment and blank lines fall through here
          begin
            @(posedge clk);
            req <= rq[NumPorts-1:0];
            for (int p = 0; p < NumPorts; p++)
            begin
              flitId[p]    <= flitKind'(kind[p]);
              pktLength[p] <= len[p][LengthWidth-1:0];
            end
            cfgWrite  <= cw[0];
            cfgAddr   <= cfgAddress'(ca[0]);
            cfgData   <= cd[LengthWidth-1:0];
            expGrant  <= arbState'(eg[5:0]);
            rowActive <= 1'b1;
            cycles++;
          end
        end
      end
      $fclose(fd);
      if (!atEnd)
      begin
        $display("Stimulus file still had rows after %0d cycles", MaxCycles);
        runBroken = 1'b1;
      end
      @(posedge clk);
      req       <= '0;
      cfgWrite  <= 1'b0;
      rowActive <= 1'b0;
      for (int p = 0; p < NumPorts; p++)
        flitId[p] <= idleFlit;
      repeat (2) @(posedge clk); // Last grant reaches the output link by now
    end

    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (runBroken || errorCount != 0)
      $display("TB FAILED");
    else
      $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
logic/routerPkg.sv
logic/holdTimer.sv
logic/arbiterConfig.sv
logic/outputArbiter.sv
logic/outputMux.sv
logic/outputPort.sv
tb/outputPortChecker.sv
tb/outputPortTb.sv

// File: tb/outputPortInput.txt
# req k0 k1 k2 k3 k4 len0 len1 len2 len3 len4 cfgWrite cfgAddr cfgData expGrant
# Ports in order Local North East West South; req, lengths, cfgData and expGrant in hex
00 0 0 0 0 0 000 000 000 000 000 0 0 000 01
1a 0 0 0 0 0 000 000 000 000 000 0 0 000 04
1a 0 0 0 0 0 000 000 000 000 000 0 0 000 10
1a 0 0 0 0 0 000 000 000 000 000 0 0 000 20
1a 0 0 0 0 0 000 000 000 000 000 0 0 000 04
00 0 0 0 0 0 000 000 000 000 000 0 0 000 01
00 1 0 0 0 0 003 000 000 000 000 0 0 000 01
03 2 0 0 0 0 000 000 000 000 000 0 0 000 02
03 2 0 0 0 0 000 000 000 000 000 0 0 000 02
03 2 0 0 0 0 000 000 000 000 000 0 0 000 02
03 2 0 0 0 0 000 000 000 000 000 0 0 000 02
03 2 0 0 0 0 000 000 000 000 000 0 0 000 04
00 0 0 0 0 0 000 000 000 000 000 0 0 000 01
00 0 0 0 1 0 000 000 000 002 000 0 0 000 01
08 0 0 0 2 0 000 000 000 000 000 0 0 000 10
18 0 0 0 2 0 000 000 000 000 000 0 0 000 10
11 0 0 0 0 0 000 000 000 000 000 0 0 000 20
11 0 0 0 0 0 000 000 000 000 000 0 0 000 02
02 0 0 0 0 0 000 000 000 000 000 0 0 000 04
0a 0 0 0 0 0 000 000 000 000 000 0 0 000 10
00 0 0 0 0 0 000 000 000 000 000 0 0 000 01
08 0 0 0 0 0 000 000 000 000 000 0 0 000 10
04 0 0 0 0 0 000 000 000 000 000 0 0 000 08
04 0 0 0 0 0 000 000 000 000 000 0 0 000 01
00 0 0 0 0 0 000 000 000 000 000 0 0 000 01
00 0 0 0 0 0 000 000 000 000 000 1 1 001 01
00 0 1 0 0 0 000 005 000 000 000 0 0 000 01
06 0 2 0 0 0 000 000 000 000 000 0 0 000 04
06 0 2 0 0 0 000 000 000 000 000 0 0 000 04
06 0 2 0 0 0 000 000 000 000 000 0 0 000 08
06 0 0 0 0 0 000 000 000 000 000 0 0 000 04
00 0 0 0 0 0 000 000 000 000 000 0 0 000 01
00 0 0 0 0 0 000 000 000 000 000 1 0 01b 01
04 0 0 0 0 0 000 000 000 000 000 0 0 000 01
04 0 0 0 0 0 000 000 000 000 000 0 0 000 01
0c 0 0 0 0 0 000 000 000 000 000 0 0 000 10
0c 0 0 0 0 0 000 000 000 000 000 0 0 000 10
04 0 0 0 0 0 000 000 000 000 000 0 0 000 01
